// File: eeprom_ctrl.f
+incdir+.
eeprom_pkg.sv
eeprom_cmd_stage.sv
eeprom_frame_seq.sv
eeprom_bit_engine.sv
eeprom_ctrl.sv
eeprom_model.sv
eeprom_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module eeprom_ctrl_tb \
    -f eeprom_ctrl.f \
    -o eeprom_ctrl_sim

./obj_dir/eeprom_ctrl_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log
then
    exit 1
fi
exit 0

// File: eeprom_ctrl_tb.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_ctrl_tb;

    typedef logic [`EE_ADDR_W-1:0] addr_t;
    typedef logic [`EE_DATA_W-1:0] data_t;

    localparam int ACK_TIMEOUT = 200 * (4 * `EE_QTR_CYCLES + 4);
    localparam int MEM_SIZE    = 1 << `EE_ADDR_W;

    logic             CLK;
    logic             RESET;
    logic             wr;
    logic             rd;
    addr_t            addr;
    data_t            wdata;
    data_t            rdata;
    logic             ack;
    logic             nack;
    logic             busy;
    logic             scl;
    logic             sda_oe;
    logic             sda_pull;
    logic             sda_in;
    logic             nack_enable;

    data_t            shadow [0:MEM_SIZE-1];
    eeprom_pkg::cmd_t exp_q [$];        // wdata holds the expected read byte
    logic             exp_nack_q [$];
    int               errors;
    int               acks_seen;
    int               acks_due;
    int               tests;
    int               tests_bad;
    logic             timed_out;

    // wired-AND bus
    assign sda_in = !sda_oe && !sda_pull;

    eeprom_ctrl dut_i
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .sda_in (sda_in),
        .rdata  (rdata),
        .ack    (ack),
        .nack   (nack),
        .busy   (busy),
        .scl    (scl),
        .sda_oe (sda_oe)
    );

    eeprom_model model_i
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .scl         (scl),
        .sda         (sda_in),
        .nack_enable (nack_enable),
        .sda_pull    (sda_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic data_t fill_byte(input addr_t a);
        return a[7:0] ^ {a[10:8], 5'b10101};
    endfunction

    // last byte stored at a by an acknowledged write
    function automatic data_t expected_read(input addr_t a);
        return shadow[a];
    endfunction

    task automatic check_data(input string what, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0d ns: %s rdata 0x%h, expected 0x%h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // every ack retires the oldest outstanding request
    always @(negedge CLK)
    begin
        eeprom_pkg::cmd_t e;
        logic             en;
        if (!RESET && ack)
        begin
            acks_seen++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("ack at %0d ns with no request outstanding", $time);
            end
            else
            begin
                e  = exp_q.pop_front();
                en = exp_nack_q.pop_front();
                check_flag("nack", nack, en);
                if (e.is_read)
                begin
                    check_data("read", rdata, e.wdata);
                end
            end
        end
    end

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && !timed_out)
        begin
            @(negedge CLK);
            n++;
            if (n >= ACK_TIMEOUT)
            begin
                timed_out = 1'b1;
                errors++;
                $display("busy stayed high for %0d cycles, giving up", n);
            end
        end
    endtask

    task automatic wait_acks();
        int n;
        n = 0;
        while (acks_seen < acks_due && !timed_out)
        begin
            @(posedge CLK);
            n++;
            if (n >= ACK_TIMEOUT)
            begin
                timed_out = 1'b1;
                errors++;
                $display("no ack from the DUT within %0d cycles, giving up", n);
            end
        end
        @(negedge CLK);
    endtask

    task automatic pulse(input logic is_rd, input addr_t a, input data_t d);
        wr    = !is_rd;
        rd    = is_rd;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic request(input logic is_rd, input addr_t a, input data_t d);
        eeprom_pkg::cmd_t e;
        e.is_read = is_rd;
        e.addr    = a;
        e.wdata   = is_rd ? expected_read(a) : d;
        exp_q.push_back(e);
        exp_nack_q.push_back(nack_enable);
        acks_due++;
        if (!is_rd && !nack_enable)
        begin
            shadow[a] = d;  // the model drops unacknowledged writes
        end
        pulse(is_rd, a, d);
    endtask

    task automatic write_byte(input addr_t a, input data_t d);
        wait_idle();
        request(1'b0, a, d);
        wait_acks();
    endtask

    task automatic read_byte(input addr_t a);
        wait_idle();
        request(1'b1, a, '0);
        wait_acks();
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors != errors_before)
        begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
        end
        else
        begin
            $display("test %0d %s: ok", tests, name);
        end
    endtask

    initial
    begin
        addr_t a;
        data_t d;
        int    e0;
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wdata       = '0;
        nack_enable = 1'b0;
        errors      = 0;
        acks_seen   = 0;
        acks_due    = 0;
        tests       = 0;
        tests_bad   = 0;
        timed_out   = 1'b0;
        void'($urandom(15066));
        for (int i = 0; i < MEM_SIZE; i++)
        begin
            shadow[i] = fill_byte(addr_t'(i));
        end
        repeat (3) @(negedge CLK);
        RESET = 1'b0;

        e0 = errors;
        repeat (20)
        begin
            @(negedge CLK);
            check_flag("scl", scl, 1'b1);
            check_flag("sda_oe", sda_oe, 1'b0);
            check_flag("busy", busy, 1'b0);
            check_flag("ack", ack, 1'b0);
        end
        end_test("idle after reset", e0);

        e0 = errors;
        write_byte(11'h2A5, 8'h3C);
        read_byte(11'h2A5);
        end_test("write then read", e0);

        e0 = errors;
        for (int i = 0; i < 40; i++)
        begin
            a = {3'(i), 8'($urandom)};  // walks all eight blocks
            d = 8'($urandom);
            write_byte(a, d);
            if ($urandom % 2 == 1)
            begin
                a = addr_t'($urandom);
            end
            read_byte(a);
        end
        end_test("random traffic", e0);

        e0 = errors;
        a = 11'h5F0;
        write_byte(a, 8'h81);
        nack_enable = 1'b1;
        write_byte(a, 8'h7E);
        nack_enable = 1'b0;
        read_byte(a);
        end_test("nack write", e0);

        e0 = errors;
        a = 11'h13B;
        wait_idle();
        request(1'b0, a, 8'hA5);
        check_flag("busy", busy, 1'b1);
        pulse(1'b0, a, 8'h5A);          // cmd stage still full
        wait_acks();
        check_flag("busy after ack", busy, 1'b0);
        read_byte(a);
        end_test("write while busy", e0);

        e0 = errors;
        a = 11'h7C4;
        wait_idle();
        request(1'b0, a, 8'hD2);
        @(negedge CLK);                 // sequencer has taken the write
        request(1'b1, a, '0);
        wait_acks();
        end_test("queued read", e0);

        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d requests never got an ack", exp_q.size());
        end
        $display("%0d tests, %0d failed, %0d errors", tests, tests_bad, errors);
        if (errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: eeprom_model.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_model
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic nack_enable,   // no acknowledge at all while high
    output logic sda_pull
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA,
        M_IGNORE
    } mstate_e;

    logic [`EE_DATA_W-1:0] mem [0:(1 << `EE_ADDR_W)-1];
    mstate_e               state;
    logic                  scl_d;
    logic                  sda_d;
    logic [3:0]            r;           // scl rising edges in this byte
    logic [`EE_DATA_W-1:0] shift;
    logic [`EE_DATA_W-1:0] obyte;       // read byte, next bit on top
    logic [2:0]            hi;
    logic                  rnw;
    logic [`EE_ADDR_W-1:0] ptr;

    initial
    begin
        for (int i = 0; i < (1 << `EE_ADDR_W); i++)
        begin
            mem[i] = 8'(i) ^ {3'(i >> 8), 5'b10101};
        end
    end

    // bus sampled on CLK, edges found against last cycle's levels
    always @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= M_IDLE;
            scl_d    <= 1'b1;
            sda_d    <= 1'b1;
            sda_pull <= 1'b0;
            r        <= 4'd0;
        end
        else
        begin
            scl_d <= scl;
            sda_d <= sda;
            if (scl && scl_d && sda_d && !sda)
            begin
                state    <= M_CTRL;     // start or repeated start
                r        <= 4'd0;
                sda_pull <= 1'b0;
            end
            else if (scl && scl_d && !sda_d && sda)
            begin
                state    <= M_IDLE;     // stop
                sda_pull <= 1'b0;
            end
            else if (scl && !scl_d && state != M_IDLE && state != M_IGNORE)
            begin
                r <= r + 4'd1;
                if (r < 4'd8)
                begin
                    shift <= {shift[`EE_DATA_W-2:0], sda};
                end
            end
            else if (!scl && scl_d)
            begin
                case (state)
                    M_CTRL:
                    begin
                        if (r == 4'd8)
                        begin
                            if (shift[7:4] == `EE_DEV_CODE && !nack_enable)
                            begin
                                sda_pull <= 1'b1;
                                hi       <= shift[3:1];
                                rnw      <= shift[0];
                            end
                            else
                            begin
                                state <= M_IGNORE;
                            end
                        end
                        else if (r == 4'd9)
                        begin
                            r <= 4'd0;
                            if (rnw)
                            begin
                                state    <= M_RDATA;
                                obyte    <= {mem[ptr][`EE_DATA_W-2:0], 1'b0};
                                sda_pull <= !mem[ptr][`EE_DATA_W-1];
                            end
                            else
                            begin
                                state    <= M_ADDR;
                                sda_pull <= 1'b0;
                            end
                        end
                    end
                    M_ADDR:
                    begin
                        if (r == 4'd8)
                        begin
                            sda_pull <= 1'b1;
                            ptr      <= {hi, shift};
                        end
                        else if (r == 4'd9)
                        begin
                            r        <= 4'd0;
                            sda_pull <= 1'b0;
                            state    <= M_WDATA;
                        end
                    end
                    M_WDATA:
                    begin
                        if (r == 4'd8)
                        begin
                            sda_pull <= 1'b1;
                            mem[ptr] <= shift;
                        end
                        else if (r == 4'd9)
                        begin
                            r        <= 4'd0;
                            sda_pull <= 1'b0;
                            state    <= M_IGNORE;   // single byte only
                        end
                    end
                    M_RDATA:
                    begin
                        if (r < 4'd8)
                        begin
                            sda_pull <= !obyte[`EE_DATA_W-1];
                            obyte    <= {obyte[`EE_DATA_W-2:0], 1'b0};
                        end
                        else if (r == 4'd8)
                        begin
                            sda_pull <= 1'b0;   // master acks or nacks
                        end
                        else
                        begin
                            r     <= 4'd0;
                            state <= M_IGNORE;
                        end
                    end
                    default:
                    begin
                        state <= state;
                    end
                endcase
            end
        end
    end

endmodule

// File: eeprom_ctrl.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_ctrl
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    input  logic                  sda_in,
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  ack,
    output logic                  nack,
    output logic                  busy,
    output logic                  scl,
    output logic                  sda_oe
);

    eeprom_pkg::cmd_t cmd;
    eeprom_pkg::sym_t sym;
    logic             cmd_valid;
    logic             cmd_take;
    logic             sym_valid;
    logic             sym_done;
    logic             rx_bit;
    logic             active;

    // pending or running
    assign busy = cmd_valid | active;

    eeprom_cmd_stage cmd_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .cmd_take  (cmd_take),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    eeprom_frame_seq seq_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .sym_done  (sym_done),
        .rx_bit    (rx_bit),
        .cmd_take  (cmd_take),
        .sym       (sym),
        .sym_valid (sym_valid),
        .active    (active),
        .rdata     (rdata),
        .ack       (ack),
        .nack      (nack)
    );

    eeprom_bit_engine bit_i
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .sym       (sym),
        .sym_valid (sym_valid),
        .sda_in    (sda_in),
        .sym_done  (sym_done),
        .rx_bit    (rx_bit),
        .scl       (scl),
        .sda_oe    (sda_oe)
    );

endmodule

// File: eeprom_bit_engine.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_bit_engine
(
    input  logic             CLK,
    input  logic             RESET,
    input  eeprom_pkg::sym_t sym,
    input  logic             sym_valid,
    input  logic             sda_in,
    output logic             sym_done,
    output logic             rx_bit,
    output logic             scl,
    output logic             sda_oe
);

    localparam int            QW    = $clog2(`EE_QTR_CYCLES + 1);
    localparam logic [QW-1:0] QLAST = QW'(`EE_QTR_CYCLES - 1);

    eeprom_pkg::sym_t cur;
    logic             run;
    logic [QW-1:0]    qcnt;
    logic [1:0]       qidx;      // quarter within the symbol
    logic             q_end;
    logic [1:0]       lines_first;
    logic [1:0]       lines_next;

    // {scl, sda_oe} during quarter q of symbol s
    function automatic logic [1:0] quarter_lines
    (
        input eeprom_pkg::sym_t s,
        input logic [1:0]       q,
        input logic             scl_now
    );
        logic scl_v;
        logic oe_v;
        scl_v = (q == 2'd1) || (q == 2'd2);
        oe_v  = 1'b0;
        case (s.kind)
            eeprom_pkg::SYM_START:
            begin
                // release, scl up, sda down, scl down
                scl_v = (q == 2'd0) ? scl_now : (q != 2'd3);
                oe_v  = q[1];
            end
            eeprom_pkg::SYM_STOP:
            begin
                // sda down, scl up, sda released
                scl_v = (q == 2'd0) ? scl_now : 1'b1;
                oe_v  = !q[1];
            end
            eeprom_pkg::SYM_BIT:
            begin
                oe_v = !s.level;
            end
            default:
            begin
                oe_v = 1'b0;    // sample, line left to the slave
            end
        endcase
        return {scl_v, oe_v};
    endfunction

    assign q_end       = (qcnt == QLAST);
    assign sym_done    = run && q_end && (qidx == 2'd3);
    assign lines_first = quarter_lines(sym, 2'd0, scl);
    assign lines_next  = quarter_lines(cur, qidx + 2'd1, scl);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            run    <= 1'b0;
            qcnt   <= '0;
            qidx   <= 2'd0;
            scl    <= 1'b1;     // bus idle
            sda_oe <= 1'b0;
        end
        else if (!run)
        begin
            if (sym_valid)
            begin
                run             <= 1'b1;
                qcnt            <= '0;
                qidx            <= 2'd0;
                {scl, sda_oe}   <= lines_first;
            end
        end
        else if (q_end)
        begin
            qcnt <= '0;
            qidx <= qidx + 2'd1;
            if (qidx == 2'd3)
            begin
                run <= 1'b0;    // lines hold until next symbol
            end
            else
            begin
                {scl, sda_oe} <= lines_next;
            end
        end
        else
        begin
            qcnt <= qcnt + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (sym_valid && !run)
        begin
            cur <= sym;
        end
        // middle of the scl high time
        if (run && q_end && qidx == 2'd1 && cur.kind == eeprom_pkg::SYM_SAMPLE)
        begin
            rx_bit <= sda_in;
        end
    end

endmodule

// File: eeprom_frame_seq.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_frame_seq
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  eeprom_pkg::cmd_t      cmd,
    input  logic                  cmd_valid,
    input  logic                  sym_done,
    input  logic                  rx_bit,
    output logic                  cmd_take,
    output eeprom_pkg::sym_t      sym,
    output logic                  sym_valid,
    output logic                  active,
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  ack,
    output logic                  nack
);

    typedef enum logic [9:0] {
        P_IDLE    = 10'b00_0000_0001,
        P_START   = 10'b00_0000_0010,
        P_CTRL_WR = 10'b00_0000_0100,
        P_ADDR    = 10'b00_0000_1000,
        P_DATA    = 10'b00_0001_0000,
        P_RESTART = 10'b00_0010_0000,
        P_CTRL_RD = 10'b00_0100_0000,
        P_DATA_RD = 10'b00_1000_0000,
        P_STOP    = 10'b01_0000_0000,
        P_FINISH  = 10'b10_0000_0000
    } phase_e;

    phase_e                phase;
    eeprom_pkg::cmd_t      cur;        // command being run
    logic [`EE_DATA_W-1:0] shreg;      // outgoing byte, msb first
    logic [`EE_DATA_W-1:0] rx_shift;
    logic [3:0]            bit_cnt;    // 0..7 data, 8 ack slot
    logic                  in_flight;
    logic                  nack_seen;
    logic                  last_slot;
    logic                  byte_phase;
    logic                  emit;
    eeprom_pkg::sym_t      next_sym;

    function automatic logic [`EE_DATA_W-1:0] ctrl_byte
    (
        input logic [`EE_ADDR_W-1:0] a,
        input logic                  rnw
    );
        return {`EE_DEV_CODE, a[`EE_ADDR_W-1:8], rnw};
    endfunction

    assign cmd_take   = (phase == P_IDLE) && cmd_valid;
    assign last_slot  = (bit_cnt == 4'(`EE_DATA_W));
    assign byte_phase = (phase == P_CTRL_WR) || (phase == P_ADDR) || (phase == P_DATA) ||
                        (phase == P_CTRL_RD) || (phase == P_DATA_RD);
    assign emit       = (phase != P_IDLE) && (phase != P_FINISH) && !in_flight;

    always_comb
    begin
        next_sym.kind  = eeprom_pkg::SYM_BIT;
        next_sym.level = shreg[`EE_DATA_W-1];
        case (phase)
            P_START, P_RESTART:
            begin
                next_sym.kind  = eeprom_pkg::SYM_START;
                next_sym.level = 1'b1;
            end
            P_STOP:
            begin
                next_sym.kind  = eeprom_pkg::SYM_STOP;
                next_sym.level = 1'b0;
            end
            P_DATA_RD:
            begin
                // eight samples, then master nack
                next_sym.kind  = last_slot ? eeprom_pkg::SYM_BIT : eeprom_pkg::SYM_SAMPLE;
                next_sym.level = 1'b1;
            end
            default:
            begin
                if (last_slot)
                begin
                    next_sym.kind  = eeprom_pkg::SYM_SAMPLE;   // slave ack
                    next_sym.level = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase     <= P_IDLE;
            sym_valid <= 1'b0;
            in_flight <= 1'b0;
            active    <= 1'b0;
            ack       <= 1'b0;
            nack      <= 1'b0;
            nack_seen <= 1'b0;
            bit_cnt   <= '0;
        end
        else
        begin
            sym_valid <= 1'b0;
            ack       <= 1'b0;

            if (emit)
            begin
                sym_valid <= 1'b1;
                sym       <= next_sym;
                in_flight <= 1'b1;
            end

            if (cmd_take)
            begin
                cur       <= cmd;
                phase     <= P_START;
                active    <= 1'b1;
                nack_seen <= 1'b0;
                bit_cnt   <= '0;
            end

            if (phase == P_FINISH)
            begin
                ack    <= 1'b1;
                nack   <= nack_seen;
                rdata  <= rx_shift;
                active <= 1'b0;
                phase  <= P_IDLE;
            end

            if (sym_done)
            begin
                in_flight <= 1'b0;
                if (byte_phase)
                begin
                    bit_cnt <= last_slot ? 4'd0 : bit_cnt + 4'd1;
                    shreg   <= shreg << 1;
                    if (last_slot && phase != P_DATA_RD)
                    begin
                        nack_seen <= nack_seen | rx_bit;    // sticky
                    end
                end
                case (phase)
                    P_START:
                    begin
                        phase <= P_CTRL_WR;
                        shreg <= ctrl_byte(cur.addr, 1'b0);
                    end
                    P_CTRL_WR:
                    begin
                        if (last_slot)
                        begin
                            phase <= P_ADDR;
                            shreg <= cur.addr[`EE_DATA_W-1:0];
                        end
                    end
                    P_ADDR:
                    begin
                        if (last_slot)
                        begin
                            // reads leave here for the repeated start
                            phase <= cur.is_read ? P_RESTART : P_DATA;
                            shreg <= cur.wdata;
                        end
                    end
                    P_DATA:
                    begin
                        if (last_slot)
                        begin
                            phase <= P_STOP;
                        end
                    end
                    P_RESTART:
                    begin
                        phase <= P_CTRL_RD;
                        shreg <= ctrl_byte(cur.addr, 1'b1);
                    end
                    P_CTRL_RD:
                    begin
                        if (last_slot)
                        begin
                            phase <= P_DATA_RD;
                        end
                    end
                    P_DATA_RD:
                    begin
                        if (last_slot)
                        begin
                            phase <= P_STOP;
                        end
                        else
                        begin
                            rx_shift <= {rx_shift[`EE_DATA_W-2:0], rx_bit};
                        end
                    end
                    P_STOP:
                    begin
                        phase <= P_FINISH;
                    end
                    default:
                    begin
                        phase <= phase;
                    end
                endcase
            end
        end
    end

endmodule

// File: eeprom_cmd_stage.sv
`timescale 1ns/1ps
`include "eeprom_config.svh"

module eeprom_cmd_stage
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    input  logic                  cmd_take,
    output eeprom_pkg::cmd_t      cmd,
    output logic                  cmd_valid
);

    logic accept;

    // one slot only, requests while full are dropped
    assign accept = !cmd_valid && (wr || rd);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cmd_valid <= 1'b0;
        end
        else if (cmd_valid)
        begin
            if (cmd_take)
            begin
                cmd_valid <= 1'b0;
            end
        end
        else if (accept)
        begin
            cmd_valid <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cmd.is_read <= !wr;     // wr wins over rd
            cmd.addr    <= addr;
            cmd.wdata   <= wdata;
        end
    end

endmodule

// File: eeprom_pkg.sv
`include "eeprom_config.svh"

package eeprom_pkg;

    // one host request as held between cmd stage and sequencer
    typedef struct packed {
        logic                  is_read;
        logic [`EE_ADDR_W-1:0] addr;
        logic [`EE_DATA_W-1:0] wdata;  // unused for reads
    } cmd_t;

    // bus symbols understood by the bit engine
    typedef enum logic [1:0] {
        SYM_START  = 2'd0,  // start or repeated start
        SYM_STOP   = 2'd1,
        SYM_BIT    = 2'd2,  // master drives level
        SYM_SAMPLE = 2'd3   // master releases sda, reads it
    } sym_kind_e;

    typedef struct packed {
        sym_kind_e kind;
        logic      level;   // only meaningful for SYM_BIT
    } sym_t;

endpackage

// File: eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// byte address of the 2 KB part, bits 10..8 go into the control byte
`define EE_ADDR_W 11

// data byte width
`define EE_DATA_W 8

// CLK cycles per quarter of one SCL bit period
// one bus symbol is four quarters
`define EE_QTR_CYCLES 2

// device type code, upper nibble of every control byte
`define EE_DEV_CODE 4'b1010

`endif
